//--- source/core_pkg.sv
// shared widths, opcode encoding and pipeline structs imported by every stage of the core.
package core_pkg;

    // data path width.
    localparam int unsigned XLEN = 64;

    // physical register index width for up to 64 registers.
    localparam int unsigned PHREG_BITS = 6;

    // one register file write port per execution lane.
    localparam int unsigned NUM_SCALAR_WB = 2;

    typedef logic [PHREG_BITS-1:0] phreg_t;
    typedef logic [XLEN-1:0]       bus64_t;

    // opcodes. everything except OP_MUL runs in the ALU lane.
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_XOR = 3'd2,
        OP_SLL = 3'd3,
        OP_LI  = 3'd4,
        OP_MUL = 3'd5
    } op_e;

    // renamed instruction as it enters the issue stage (54 bits).
    typedef struct packed {
        logic        valid;
        op_e         op;
        phreg_t      rd;
        phreg_t      rs1;
        phreg_t      rs2;
        logic [31:0] imm;
    } issue_t;

    // operands ready for a lane (138 bits).
    typedef struct packed {
        logic   valid;
        op_e    op;
        phreg_t rd;
        bus64_t op1;
        bus64_t op2;
    } lane_op_t;

    // a finished result and also the shape of one register file write (71 bits).
    typedef struct packed {
        logic   valid;
        phreg_t rd;
        bus64_t data;
    } commit_t;

endpackage

//--- source/issue_stage.sv
// issue stage: reads operands for the incoming instruction and registers it into its lane slot.
`timescale 1ns/1ps

module issue_stage #(
    parameter int unsigned NUM_PHYS_REGS = 64
) (
    input  logic               clk_i,
    input  logic               rstn_i,
    // instruction from the rename side, one per cycle, no ready.
    input  core_pkg::issue_t   issue_i,
    // register file read side, data comes back in the same cycle.
    output core_pkg::phreg_t   rs1_addr_o,
    output core_pkg::phreg_t   rs2_addr_o,
    input  core_pkg::bus64_t   rs1_data_i,
    input  core_pkg::bus64_t   rs2_data_i,
    // one slot per lane.
    output core_pkg::lane_op_t alu_op_o,
    output core_pkg::lane_op_t mul_op_o
);
    import core_pkg::*;

    // lane selection.
    logic     to_mul;
    // operand pair and payload shared by both slots.
    lane_op_t next_op;

    // operands are read straight from the instruction's sources.
    assign rs1_addr_o = issue_i.rs1;
    assign rs2_addr_o = issue_i.rs2;

    // decode.
    always_comb begin
        to_mul       = (issue_i.op == OP_MUL);
        next_op.op   = issue_i.op;
        next_op.rd   = issue_i.rd;
        next_op.valid = issue_i.valid;
        if (issue_i.op == OP_LI) begin
            // immediate is sign extended, second operand unused.
            next_op.op1 = {{(XLEN-32){issue_i.imm[31]}}, issue_i.imm};
            next_op.op2 = '0;
        end else begin
            next_op.op1 = rs1_data_i;
            next_op.op2 = rs2_data_i;
        end
    end

    // only the selected slot sees valid.
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            alu_op_o.valid <= 1'b0;
            mul_op_o.valid <= 1'b0;
        end else begin
            alu_op_o.valid <= next_op.valid && !to_mul;
            mul_op_o.valid <= next_op.valid && to_mul;
        end
    end

    // payload goes to both slots, the valid decides who uses it.
    always_ff @(posedge clk_i) begin
        alu_op_o.op  <= next_op.op;
        alu_op_o.rd  <= next_op.rd;
        alu_op_o.op1 <= next_op.op1;
        alu_op_o.op2 <= next_op.op2;
        mul_op_o.op  <= next_op.op;
        mul_op_o.rd  <= next_op.rd;
        mul_op_o.op1 <= next_op.op1;
        mul_op_o.op2 <= next_op.op2;
    end

    // upstream must hand over a legal opcode and a destination that exists.
    a_issue_legal: assert property (@(posedge clk_i) disable iff (!rstn_i)
        issue_i.valid |-> (issue_i.op inside {OP_ADD, OP_SUB, OP_XOR, OP_SLL, OP_LI, OP_MUL})
                          && (issue_i.rd < NUM_PHYS_REGS))
        else $error("issue: illegal opcode or destination register");

endmodule

//--- source/regfile.sv
// physical register file with two write ports, two read ports, a zero register and bypass.
`timescale 1ns/1ps

module regfile #(
    parameter int unsigned NUM_PHYS_REGS = 64
) (
    input  logic                                           clk_i,
    input  logic                                           rstn_i,
    // write ports with port 0 from the ALU lane and port 1 from the multiplier.
    input  logic             [core_pkg::NUM_SCALAR_WB-1:0] write_enable_i,
    input  core_pkg::phreg_t [core_pkg::NUM_SCALAR_WB-1:0] write_addr_i,
    input  core_pkg::bus64_t [core_pkg::NUM_SCALAR_WB-1:0] write_data_i,
    // read ports.
    input  core_pkg::phreg_t                               read_addr1_i,
    input  core_pkg::phreg_t                               read_addr2_i,
    output core_pkg::bus64_t                               read_data1_o,
    output core_pkg::bus64_t                               read_data2_o
);
    import core_pkg::*;

    // register 0 has no storage.
    bus64_t registers [NUM_PHYS_REGS-1:1];

    // one read port.
    // a write in flight this cycle overrides the stored value.
    // ports are scanned from the highest down so port 0 has the last word.
    function automatic bus64_t read_port(input phreg_t addr);
        bus64_t data;
        data = '0;
        if (addr != '0) begin
            data = registers[addr];
            for (int i = NUM_SCALAR_WB - 1; i >= 0; i--) begin
                if (write_enable_i[i] && (write_addr_i[i] == addr)) begin
                    data = write_data_i[i];
                end
            end
        end
        return data;
    endfunction

    // reads follow the storage and the write ports as well as the address.
    always_comb begin
        read_data1_o = read_port(read_addr1_i);
        read_data2_o = read_port(read_addr2_i);
    end

    // writes.
    // same scan order as the bypass so port 0 also wins in storage.
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int r = 1; r < NUM_PHYS_REGS; r++) begin
                registers[r] <= '0;
            end
        end else begin
            for (int i = NUM_SCALAR_WB - 1; i >= 0; i--) begin
                // writes to register 0 are dropped.
                if (write_enable_i[i] && (write_addr_i[i] != '0)) begin
                    registers[write_addr_i[i]] <= write_data_i[i];
                end
            end
        end
    end

    // the writeback side must never address beyond the physical registers.
    for (genvar p = 0; p < NUM_SCALAR_WB; p++) begin : g_wr_check
        a_wr_addr: assert property (@(posedge clk_i) disable iff (!rstn_i)
            write_enable_i[p] |-> (write_addr_i[p] < NUM_PHYS_REGS))
            else $error("regfile: write port %0d address out of range", p);
    end

endmodule

//--- source/exec_lanes.sv
// execution lanes: a one-cycle ALU lane and a two-stage pipelined multiply lane.
`timescale 1ns/1ps

module exec_lanes (
    input  logic               clk_i,
    input  logic               rstn_i,
    // operands from issue.
    input  core_pkg::lane_op_t alu_op_i,
    input  core_pkg::lane_op_t mul_op_i,
    // registered results toward writeback.
    output core_pkg::commit_t  alu_res_o,
    output core_pkg::commit_t  mul_res_o
);
    import core_pkg::*;

    // multiplier first stage.
    // low 64 bits of op1 * op2 split around the 32-bit boundary of op2.
    typedef struct packed {
        logic        valid;
        phreg_t      rd;
        bus64_t      pp_lo;
        logic [31:0] pp_hi;
    } mul_stage_t;

    bus64_t     alu_result;
    mul_stage_t mul_s1;
    bus64_t     mul_b_lo;

    // ALU lane.
    always_comb begin
        case (alu_op_i.op)
            OP_ADD:  alu_result = alu_op_i.op1 + alu_op_i.op2;
            OP_SUB:  alu_result = alu_op_i.op1 - alu_op_i.op2;
            OP_XOR:  alu_result = alu_op_i.op1 ^ alu_op_i.op2;
            // shift amount is the low 6 bits only.
            OP_SLL:  alu_result = alu_op_i.op1 << alu_op_i.op2[5:0];
            // immediate already sign extended in issue.
            OP_LI:   alu_result = alu_op_i.op1;
            default: alu_result = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            alu_res_o.valid <= 1'b0;
        end else begin
            alu_res_o.valid <= alu_op_i.valid;
        end
        alu_res_o.rd   <= alu_op_i.rd;
        alu_res_o.data <= alu_result;
    end

    // multiply lane, stage 1.
    // full-width times low half, and low half times high half.
    // only 32 bits of the second product survive the shift by 32.
    assign mul_b_lo = {32'b0, mul_op_i.op2[31:0]};

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            mul_s1.valid <= 1'b0;
        end else begin
            mul_s1.valid <= mul_op_i.valid;
        end
        mul_s1.rd    <= mul_op_i.rd;
        mul_s1.pp_lo <= mul_op_i.op1 * mul_b_lo;
        mul_s1.pp_hi <= mul_op_i.op1[31:0] * mul_op_i.op2[63:32];
    end

    // multiply lane, stage 2.
    // sum of partial products, a new multiply may enter behind it every cycle.
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            mul_res_o.valid <= 1'b0;
        end else begin
            mul_res_o.valid <= mul_s1.valid;
        end
        mul_res_o.rd   <= mul_s1.rd;
        mul_res_o.data <= mul_s1.pp_lo + {mul_s1.pp_hi, 32'b0};
    end

endmodule

//--- source/writeback_stage.sv
// writeback stage: registers lane results into commit slots that also drive the register file writes.
`timescale 1ns/1ps

module writeback_stage #(
    parameter int unsigned NUM_PHYS_REGS = 64
) (
    input  logic                                           clk_i,
    input  logic                                           rstn_i,
    // results from the lanes.
    input  core_pkg::commit_t                              alu_res_i,
    input  core_pkg::commit_t                              mul_res_i,
    // commit slots, slot 0 for the ALU lane, slot 1 for the multiplier.
    output core_pkg::commit_t [core_pkg::NUM_SCALAR_WB-1:0] commit_o,
    // register file write ports.
    output logic              [core_pkg::NUM_SCALAR_WB-1:0] wr_en_o,
    output core_pkg::phreg_t  [core_pkg::NUM_SCALAR_WB-1:0] wr_addr_o,
    output core_pkg::bus64_t  [core_pkg::NUM_SCALAR_WB-1:0] wr_data_o
);
    import core_pkg::*;

    // lane results ordered by write port.
    commit_t [NUM_SCALAR_WB-1:0] lane_res;

    assign lane_res[0] = alu_res_i;
    assign lane_res[1] = mul_res_i;

    // commit registers, visible for one cycle each.
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < NUM_SCALAR_WB; i++) begin
            if (!rstn_i) begin
                commit_o[i].valid <= 1'b0;
            end else begin
                commit_o[i].valid <= lane_res[i].valid;
            end
            commit_o[i].rd   <= lane_res[i].rd;
            commit_o[i].data <= lane_res[i].data;
        end
    end

    // the write lands in the register file on the edge that retires the commit.
    always_comb begin
        for (int i = 0; i < NUM_SCALAR_WB; i++) begin
            wr_en_o[i]   = commit_o[i].valid;
            wr_addr_o[i] = commit_o[i].rd;
            wr_data_o[i] = commit_o[i].data;
        end
    end

    // commit valids are known once out of reset.
    // a valid commit names a register that exists.
    for (genvar s = 0; s < NUM_SCALAR_WB; s++) begin : g_commit_check
        a_commit_known: assert property (@(posedge clk_i) disable iff (!rstn_i)
            !$isunknown(commit_o[s].valid)
            && (!commit_o[s].valid || (commit_o[s].rd < NUM_PHYS_REGS)))
            else $error("writeback: slot %0d valid unknown or rd out of range", s);
    end

endmodule

//--- source/exec_core_top.sv
// top of the execution back end: issue, register file, execution lanes and writeback.
`timescale 1ns/1ps

module exec_core_top #(
    parameter int unsigned NUM_PHYS_REGS = 64
) (
    input  logic                                            clk_i,
    input  logic                                            rstn_i,
    // renamed instruction stream, taken whenever valid.
    input  core_pkg::issue_t                                issue_i,
    // one commit slot per lane.
    output core_pkg::commit_t [core_pkg::NUM_SCALAR_WB-1:0] commit_o
);
    import core_pkg::*;

    // operand reads.
    phreg_t   rs1_addr;
    phreg_t   rs2_addr;
    bus64_t   rs1_data;
    bus64_t   rs2_data;

    // issue to lanes.
    lane_op_t alu_op;
    lane_op_t mul_op;

    // lanes to writeback.
    commit_t  alu_res;
    commit_t  mul_res;

    // writeback to register file.
    logic   [NUM_SCALAR_WB-1:0] wr_en;
    phreg_t [NUM_SCALAR_WB-1:0] wr_addr;
    bus64_t [NUM_SCALAR_WB-1:0] wr_data;

    issue_stage #(
        .NUM_PHYS_REGS (NUM_PHYS_REGS)
    ) i_issue (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .issue_i    (issue_i),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .alu_op_o   (alu_op),
        .mul_op_o   (mul_op)
    );

    regfile #(
        .NUM_PHYS_REGS (NUM_PHYS_REGS)
    ) i_regfile (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .write_enable_i (wr_en),
        .write_addr_i   (wr_addr),
        .write_data_i   (wr_data),
        .read_addr1_i   (rs1_addr),
        .read_addr2_i   (rs2_addr),
        .read_data1_o   (rs1_data),
        .read_data2_o   (rs2_data)
    );

    exec_lanes i_lanes (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .alu_op_i  (alu_op),
        .mul_op_i  (mul_op),
        .alu_res_o (alu_res),
        .mul_res_o (mul_res)
    );

    writeback_stage #(
        .NUM_PHYS_REGS (NUM_PHYS_REGS)
    ) i_writeback (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .alu_res_i (alu_res),
        .mul_res_i (mul_res),
        .commit_o  (commit_o),
        .wr_en_o   (wr_en),
        .wr_addr_o (wr_addr),
        .wr_data_o (wr_data)
    );

endmodule

//--- include/tb_program.svh
// instruction table for the execution core testbench, included inside the testbench module.

// a row either issues one instruction or holds reset for one cycle.
typedef enum logic [1:0] {
    INSN,
    RSTN
} row_kind_e;

// one table row, idle gap cycles follow the row itself.
typedef struct packed {
    logic [3:0]  test;
    row_kind_e   kind;
    op_e         op;
    phreg_t      rd;
    phreg_t      rs1;
    phreg_t      rs2;
    logic [31:0] imm;
    logic        rand_imm;
    logic        has_exp;
    bus64_t      exp_data;
    logic [3:0]  gap;
} tb_row_t;

localparam int NUM_ROWS = 35;

string test_names [1:6] = '{"load immediate", "random alu", "multiply", "bypass",
                            "write collision", "reset"};

// test, kind, op, rd, rs1, rs2, imm, random imm, expected given, expected data, idle gap.
tb_row_t program_rows [NUM_ROWS] = '{
    '{4'd1, INSN, OP_LI, 6'd1, 6'd0, 6'd0, 32'h12345678, 1'b0, 1'b1, 64'h12345678, 4'd0},
    '{4'd1, INSN, OP_LI, 6'd2, 6'd0, 6'd0, 32'h80000001, 1'b0, 1'b1, 64'hffffffff80000001, 4'd0},
    '{4'd1, INSN, OP_LI, 6'd0, 6'd0, 6'd0, 32'h0000beef, 1'b0, 1'b1, 64'hbeef, 4'd2},
    '{4'd1, INSN, OP_ADD, 6'd3, 6'd1, 6'd0, 32'h0, 1'b0, 1'b1, 64'h12345678, 4'd0},
    '{4'd1, INSN, OP_ADD, 6'd4, 6'd2, 6'd0, 32'h0, 1'b0, 1'b1, 64'hffffffff80000001, 4'd0},
    '{4'd1, INSN, OP_ADD, 6'd5, 6'd0, 6'd0, 32'h0, 1'b0, 1'b1, 64'h0, 4'd4},
    '{4'd2, INSN, OP_LI, 6'd6, 6'd0, 6'd0, 32'h0, 1'b1, 1'b0, 64'h0, 4'd0},
    '{4'd2, INSN, OP_LI, 6'd7, 6'd0, 6'd0, 32'h0, 1'b1, 1'b0, 64'h0, 4'd0},
    '{4'd2, INSN, OP_LI, 6'd8, 6'd0, 6'd0, 32'h0, 1'b1, 1'b0, 64'h0, 4'd2},
    '{4'd2, INSN, OP_ADD, 6'd9, 6'd6, 6'd7, 32'h0, 1'b0, 1'b0, 64'h0, 4'd0},
    '{4'd2, INSN, OP_SUB, 6'd10, 6'd6, 6'd7, 32'h0, 1'b0, 1'b0, 64'h0, 4'd0},
    '{4'd2, INSN, OP_XOR, 6'd11, 6'd7, 6'd8, 32'h0, 1'b0, 1'b0, 64'h0, 4'd0},
    '{4'd2, INSN, OP_SLL, 6'd12, 6'd6, 6'd8, 32'h0, 1'b0, 1'b0, 64'h0, 4'd0},
    '{4'd2, INSN, OP_SLL, 6'd13, 6'd8, 6'd7, 32'h0, 1'b0, 1'b0, 64'h0, 4'd0},
    '{4'd2, INSN, OP_SUB, 6'd14, 6'd9, 6'd10, 32'h0, 1'b0, 1'b0, 64'h0, 4'd4},
    '{4'd3, INSN, OP_MUL, 6'd15, 6'd6, 6'd7, 32'h0, 1'b0, 1'b0, 64'h0, 4'd0},
    '{4'd3, INSN, OP_MUL, 6'd16, 6'd8, 6'd9, 32'h0, 1'b0, 1'b0, 64'h0, 4'd0},
    '{4'd3, INSN, OP_MUL, 6'd17, 6'd10, 6'd11, 32'h0, 1'b0, 1'b0, 64'h0, 4'd4},
    '{4'd4, INSN, OP_LI, 6'd20, 6'd0, 6'd0, 32'h00000aaa, 1'b0, 1'b1, 64'haaa, 4'd2},
    '{4'd4, INSN, OP_LI, 6'd20, 6'd0, 6'd0, 32'h00000bbb, 1'b0, 1'b1, 64'hbbb, 4'd1},
    '{4'd4, INSN, OP_ADD, 6'd21, 6'd20, 6'd0, 32'h0, 1'b0, 1'b1, 64'haaa, 4'd0},
    '{4'd4, INSN, OP_ADD, 6'd22, 6'd20, 6'd0, 32'h0, 1'b0, 1'b1, 64'hbbb, 4'd3},
    '{4'd5, INSN, OP_MUL, 6'd23, 6'd6, 6'd7, 32'h0, 1'b0, 1'b0, 64'h0, 4'd0},
    '{4'd5, INSN, OP_LI, 6'd23, 6'd0, 6'd0, 32'h00005555, 1'b0, 1'b1, 64'h5555, 4'd2},
    '{4'd5, INSN, OP_ADD, 6'd24, 6'd23, 6'd0, 32'h0, 1'b0, 1'b1, 64'h5555, 4'd1},
    '{4'd5, INSN, OP_ADD, 6'd25, 6'd23, 6'd0, 32'h0, 1'b0, 1'b1, 64'h5555, 4'd3},
    '{4'd6, INSN, OP_MUL, 6'd26, 6'd6, 6'd7, 32'h0, 1'b0, 1'b0, 64'h0, 4'd0},
    '{4'd6, INSN, OP_LI, 6'd27, 6'd0, 6'd0, 32'h00000001, 1'b0, 1'b1, 64'h1, 4'd0},
    '{4'd6, INSN, OP_ADD, 6'd28, 6'd6, 6'd7, 32'h0, 1'b0, 1'b0, 64'h0, 4'd0},
    '{4'd6, RSTN, OP_ADD, 6'd0, 6'd0, 6'd0, 32'h0, 1'b0, 1'b0, 64'h0, 4'd1},
    '{4'd6, INSN, OP_ADD, 6'd29, 6'd1, 6'd0, 32'h0, 1'b0, 1'b1, 64'h0, 4'd0},
    '{4'd6, INSN, OP_ADD, 6'd30, 6'd6, 6'd0, 32'h0, 1'b0, 1'b1, 64'h0, 4'd0},
    '{4'd6, INSN, OP_ADD, 6'd31, 6'd15, 6'd23, 32'h0, 1'b0, 1'b1, 64'h0, 4'd0},
    '{4'd6, INSN, OP_ADD, 6'd32, 6'd20, 6'd26, 32'h0, 1'b0, 1'b1, 64'h0, 4'd0},
    '{4'd6, INSN, OP_ADD, 6'd33, 6'd9, 6'd17, 32'h0, 1'b0, 1'b1, 64'h0, 4'd4}
};

//--- test/tb_exec_core.sv
// testbench for exec_core_top: applies the instruction table and checks commits against a model.
`timescale 1ns/1ps

module tb_exec_core;
    import core_pkg::*;

    localparam int NUM_PHYS_REGS = 64;
    localparam int CLK_PERIOD    = 20;
    localparam int RESET_CYCLES  = 10;
    localparam int DRAIN_CYCLES  = 4;
    localparam int SEED          = 87;

    `include "tb_program.svh"

    // edges count from the first clock after reset release, a row spans at most 16 cycles.
    localparam int MAX_EDGES = NUM_ROWS * 17 + DRAIN_CYCLES + 8;

    logic                        clk;
    logic                        rstn;
    issue_t                      issue;
    commit_t [NUM_SCALAR_WB-1:0] commit;

    // reference model registers, entry 0 is never written.
    bus64_t  model_regs [NUM_PHYS_REGS];
    // expected commit per edge and port.
    commit_t expected [MAX_EDGES][NUM_SCALAR_WB];
    int      applied_edge;
    int      cyc;
    int      checks;
    int      errors;
    int      test_errors;

    exec_core_top #(
        .NUM_PHYS_REGS (NUM_PHYS_REGS)
    ) i_dut (
        .clk_i    (clk),
        .rstn_i   (rstn),
        .issue_i  (issue),
        .commit_o (commit)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_value(input bus64_t actual, input bus64_t exp, input string what);
        checks++;
        if (actual !== exp) begin
            errors++;
            test_errors++;
            $display("Fail at time %0t: %s, got %h, expected %h", $time, what, actual, exp);
        end
    endtask

    // lane result as the operation defines it.
    function automatic bus64_t compute_result(input op_e op, input bus64_t a, input bus64_t b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_XOR:  return a ^ b;
            OP_SLL:  return a << b[5:0];
            OP_MUL:  return a * b;
            default: return a;
        endcase
    endfunction

    // commits visible up to this edge land in the model, port 0 last so it wins a collision.
    task automatic apply_commits(input int upto);
        for (int e = applied_edge + 1; e <= upto; e++) begin
            for (int p = NUM_SCALAR_WB - 1; p >= 0; p--) begin
                if (expected[e][p].valid && (expected[e][p].rd != '0)) begin
                    model_regs[expected[e][p].rd] = expected[e][p].data;
                end
            end
        end
        applied_edge = upto;
    endtask

    // reset zeroes the registers and cancels everything still in flight.
    task automatic clear_model(input int from);
        foreach (model_regs[r]) begin
            model_regs[r] = '0;
        end
        for (int e = from + 1; e < MAX_EDGES; e++) begin
            for (int p = 0; p < NUM_SCALAR_WB; p++) begin
                expected[e][p] = '0;
            end
        end
    endtask

    task automatic check_commits(input int e);
        for (int p = 0; p < NUM_SCALAR_WB; p++) begin
            if (commit[p].valid !== expected[e][p].valid) begin
                errors++;
                test_errors++;
                if (expected[e][p].valid) begin
                    $display("port %0d: commit to register %0d did not appear at %0t",
                             p, expected[e][p].rd, $time);
                end else begin
                    $display("port %0d: a commit appeared at %0t where none was due", p, $time);
                end
            end else if (expected[e][p].valid) begin
                check_value(64'(commit[p].rd), 64'(expected[e][p].rd),
                            $sformatf("port %0d destination", p));
                check_value(commit[p].data, expected[e][p].data,
                            $sformatf("port %0d data for register %0d", p, expected[e][p].rd));
            end
        end
    endtask

    // one clock: drive the row or an idle gap, predict its commit, check the commits of this edge.
    task automatic run_cycle(input tb_row_t row, input logic first);
        bus64_t      op1;
        bus64_t      op2;
        logic [31:0] imm;
        int          port;
        @(posedge clk);
        apply_commits(cyc);
        #1;
        rstn  = 1'b1;
        issue = '0;
        if (first && (row.kind == RSTN)) begin
            rstn = 1'b0;
            clear_model(cyc);
        end else if (first) begin
            imm = row.rand_imm ? $urandom() : row.imm;
            // operands see every commit visible in this cycle.
            op1  = (row.op == OP_LI) ? {{32{imm[31]}}, imm} : model_regs[row.rs1];
            op2  = (row.op == OP_LI) ? '0 : model_regs[row.rs2];
            port = (row.op == OP_MUL) ? 1 : 0;
            // ALU results show after edge +3 of this count, multiplies one edge later.
            expected[cyc + 3 + port][port] = '{valid: 1'b1, rd: row.rd,
                data: row.has_exp ? row.exp_data : compute_result(row.op, op1, op2)};
            issue = '{valid: 1'b1, op: row.op, rd: row.rd, rs1: row.rs1, rs2: row.rs2, imm: imm};
        end
        @(negedge clk);
        check_commits(cyc);
        cyc++;
    endtask

    task automatic report_test(input int id);
        $display("test %0d (%s) finished with %0d errors", id, test_names[id], test_errors);
        test_errors = 0;
    endtask

    function automatic int total_cycles();
        int n;
        n = 0;
        foreach (program_rows[i]) begin
            n += 1 + int'(program_rows[i].gap);
        end
        return n;
    endfunction

    initial begin
        tb_row_t row;
        int      cur_test;
        void'($urandom(SEED));
        rstn         = 1'b0;
        issue        = '0;
        cyc          = 0;
        checks       = 0;
        errors       = 0;
        test_errors  = 0;
        applied_edge = -1;
        cur_test     = 0;
        clear_model(-1);
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rstn = 1'b1;
        foreach (program_rows[i]) begin
            row = program_rows[i];
            if (int'(row.test) != cur_test) begin
                if (cur_test != 0) begin
                    report_test(cur_test);
                end
                cur_test = int'(row.test);
            end
            for (int g = 0; g <= int'(row.gap); g++) begin
                run_cycle(row, g == 0);
            end
        end
        // let the last multiply drain.
        repeat (DRAIN_CYCLES) run_cycle(row, 1'b0);
        report_test(cur_test);
        $display("all tests done: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // watchdog, the whole table plus reset, drain and a margin.
    initial begin
        #(CLK_PERIOD * (RESET_CYCLES + total_cycles() + DRAIN_CYCLES + 20));
        $display("timeout: the table did not finish in the expected time");
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

//--- tb.f
+incdir+include
source/core_pkg.sv
source/issue_stage.sv
source/regfile.sv
source/exec_lanes.sv
source/writeback_stage.sv
source/exec_core_top.sv
test/tb_exec_core.sv

//--- run_sim.sh
#!/bin/sh
# compile with Verilator, run the testbench, pass only when it reports a pass.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f \
    --top-module tb_exec_core -o tb_exec_core
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

output=$(./obj_dir/tb_exec_core 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "Simulation finished: PASS"; then
    exit 0
fi
echo "pass message not found"
exit 1
